// ==== alu_pkg.sv ====
package alu_pkg;

	localparam int XLEN = 32;
	localparam int SHAMT_W = $clog2(XLEN);
	localparam int UIMM_W = 20;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [2*XLEN-1:0] dword_t;
	typedef logic [UIMM_W-1:0] uimm_t;
	typedef logic [4:0] alu_op_t;

	// Opcode map, unused codes return zero
	localparam alu_op_t OP_ADD    = 5'd0;
	localparam alu_op_t OP_SUB    = 5'd1;
	localparam alu_op_t OP_SLL    = 5'd2;
	localparam alu_op_t OP_SLT    = 5'd3;
	localparam alu_op_t OP_SLTU   = 5'd4;
	localparam alu_op_t OP_XOR    = 5'd5;
	localparam alu_op_t OP_SRL    = 5'd6;
	localparam alu_op_t OP_SRA    = 5'd7;
	localparam alu_op_t OP_OR     = 5'd8;
	localparam alu_op_t OP_AND    = 5'd9;
	localparam alu_op_t OP_SUBU   = 5'd10;
	localparam alu_op_t OP_LUI    = 5'd11;
	localparam alu_op_t OP_AUIPC  = 5'd12;
	localparam alu_op_t OP_MUL    = 5'd13;
	localparam alu_op_t OP_MULH   = 5'd14;
	localparam alu_op_t OP_MULHSU = 5'd15;
	localparam alu_op_t OP_MULHU  = 5'd16;
	localparam alu_op_t OP_DIV    = 5'd17;
	localparam alu_op_t OP_DIVU   = 5'd18;
	localparam alu_op_t OP_REM    = 5'd19;
	localparam alu_op_t OP_REMU   = 5'd20;

	localparam int MUL_LATENCY = 8;
	localparam int DIV_STEPS = 16;                // Two quotient bits per step
	localparam int DIV_LATENCY = DIV_STEPS + 2;   // Plus input and output stage

	localparam int LAT_W = $clog2(DIV_LATENCY + 1);
	typedef logic [LAT_W-1:0] lat_t;

	typedef struct packed {
		alu_op_t op;
		word_t   rs1;
		word_t   rs2;
		logic    use_imm;    // Operand B from I-type immediate
		word_t   itype_imm;
		uimm_t   upper_imm;  // LUI / AUIPC immediate
		word_t   pc;
	} alu_req_t;

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} stall_state_e;

endpackage

// ==== alu_unit.f ====
alu_pkg.sv
int_alu.sv
pipe_mult.sv
pipe_div.sv
stall_fsm.sv
latency_timer.sv
alu_unit.sv
tb_alu_unit.sv

// ==== alu_unit.sv ====
`timescale 1ns/1ns

module alu_unit
	import alu_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  alu_req_t req,
	output word_t    result,
	output logic     stall
);

	dword_t mul_a;
	dword_t mul_b;
	dword_t product;
	word_t  op_a;
	word_t  op_b;
	logic   is_signed;
	word_t  quotient;
	word_t  remainder;
	logic   load;
	lat_t   load_value;
	logic   expired;

	int_alu u_int_alu (
		.req       (req),
		.product   (product),
		.quotient  (quotient),
		.remainder (remainder),
		.mul_a     (mul_a),
		.mul_b     (mul_b),
		.op_a      (op_a),
		.op_b      (op_b),
		.is_signed (is_signed),
		.result    (result)
	);

	pipe_mult u_pipe_mult (.clk(clk), .reset(reset), .a(mul_a), .b(mul_b), .product(product));

	pipe_div u_pipe_div (
		.clk       (clk),
		.reset     (reset),
		.numer     (op_a),
		.denom     (op_b),
		.is_signed (is_signed),
		.quotient  (quotient),
		.remainder (remainder)
	);

	stall_fsm u_stall_fsm (
		.clk        (clk),
		.reset      (reset),
		.op         (req.op),
		.expired    (expired),
		.load       (load),
		.load_value (load_value),
		.stall      (stall)
	);

	latency_timer u_latency_timer (
		.clk        (clk),
		.reset      (reset),
		.load       (load),
		.load_value (load_value),
		.expired    (expired)
	);

endmodule

// ==== alu_unit_stim.txt ====
# op rs1 rs2 use_imm itype_imm upper_imm pc expected, all hex
# Long ops are grouped so that they run back to back
00 00000005 00000007 0 00000000 00000 00000000 0000000c
00 00001000 12345678 1 fffffff0 00000 00000000 00000ff0
01 00000003 00000005 0 00000000 00000 00000000 fffffffe
01 00000100 00000000 1 00000001 00000 00000000 000000ff
02 00000001 0000001f 0 00000000 00000 00000000 80000000
02 0000000f 00000000 1 00000024 00000 00000000 000000f0
03 ffffffff 00000001 0 00000000 00000 00000000 00000001
03 00000005 00000000 1 fffffffb 00000 00000000 00000000
04 ffffffff 00000001 0 00000000 00000 00000000 00000000
04 00000001 00000000 1 ffffffff 00000 00000000 00000001
05 a5a5a5a5 0f0f0f0f 0 00000000 00000 00000000 aaaaaaaa
05 12345678 00000000 1 ffffffff 00000 00000000 edcba987
06 80000000 00000004 0 00000000 00000 00000000 08000000
07 80000000 00000004 0 00000000 00000 00000000 f8000000
07 f0000000 00000000 1 0000001c 00000 00000000 ffffffff
08 00ff0000 000000ff 0 00000000 00000 00000000 00ff00ff
09 12345678 00000000 1 00000ff0 00000 00000000 00000670
0a 00000005 00000003 0 00000000 00000 00000000 00000000
0a 00000003 00000005 0 00000000 00000 00000000 ffffffff
0b 00000000 00000000 0 00000000 12345 00000000 12345000
0c 00000000 00000000 0 00000000 00001 00400000 00401000
0d 00000007 00000006 0 00000000 00000 00000000 0000002a
0d fffffffd 00000000 1 00000005 00000 00000000 fffffff1
0e 80000000 80000000 0 00000000 00000 00000000 40000000
0e fffffffe 00000003 0 00000000 00000 00000000 ffffffff
0f ffffffff ffffffff 0 00000000 00000 00000000 ffffffff
10 ffffffff ffffffff 0 00000000 00000 00000000 fffffffe
10 80000000 00000004 0 00000000 00000 00000000 00000002
11 00000014 fffffffa 0 00000000 00000 00000000 fffffffd
13 00000014 fffffffa 0 00000000 00000 00000000 00000002
11 ffffffec 00000006 0 00000000 00000 00000000 fffffffd
13 ffffffec 00000006 0 00000000 00000 00000000 fffffffe
11 fffffff9 fffffffe 0 00000000 00000 00000000 00000003
13 fffffff9 fffffffe 0 00000000 00000 00000000 ffffffff
12 ffffffff 00000010 0 00000000 00000 00000000 0fffffff
14 ffffffff 00000010 0 00000000 00000 00000000 0000000f
12 00000064 00000000 1 00000007 00000 00000000 0000000e
14 00000064 00000000 1 00000007 00000 00000000 00000002
11 00001234 00000000 0 00000000 00000 00000000 ffffffff
13 00001234 00000000 0 00000000 00000 00000000 00001234
13 fffffff9 00000000 0 00000000 00000 00000000 fffffff9
12 80000000 00000000 0 00000000 00000 00000000 ffffffff
14 ffffff00 00000000 0 00000000 00000 00000000 ffffff00
11 80000000 ffffffff 0 00000000 00000 00000000 80000000
13 80000000 ffffffff 0 00000000 00000 00000000 00000000
00 0000000a 00000000 1 00000001 00000 00000000 0000000b

// ==== int_alu.sv ====
`timescale 1ns/1ns

module int_alu
	import alu_pkg::*;
(
	input  alu_req_t req,
	input  dword_t   product,
	input  word_t    quotient,
	input  word_t    remainder,
	output dword_t   mul_a,
	output dword_t   mul_b,
	output word_t    op_a,
	output word_t    op_b,
	output logic     is_signed,
	output word_t    result
);

	word_t  upper;
	logic   a_unsigned;
	logic   b_unsigned;
	dword_t a_sext;
	dword_t b_sext;

	assign op_a = req.rs1;
	assign op_b = req.use_imm ? req.itype_imm : req.rs2;

	assign upper = {req.upper_imm, {(XLEN-UIMM_W){1'b0}}};

	// MULHU treats both operands as unsigned, MULHSU only rs2
	assign a_unsigned = (req.op == OP_MULHU);
	assign b_unsigned = (req.op == OP_MULHU) || (req.op == OP_MULHSU);

	assign a_sext = {{XLEN{op_a[XLEN-1]}}, op_a};
	assign b_sext = {{XLEN{op_b[XLEN-1]}}, op_b};

	assign mul_a = a_unsigned ? {{XLEN{1'b0}}, op_a} : a_sext;
	assign mul_b = b_unsigned ? {{XLEN{1'b0}}, op_b} : b_sext;

	assign is_signed = (req.op == OP_DIV) || (req.op == OP_REM);

	always_comb begin
		case (req.op)
			OP_ADD:    result = op_a + op_b;
			OP_SUB:    result = op_a - op_b;
			OP_SLL:    result = op_a << op_b[SHAMT_W-1:0];
			OP_SLT:    result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
			OP_SLTU:   result = (op_a < op_b) ? 32'd1 : 32'd0;
			OP_XOR:    result = op_a ^ op_b;
			OP_SRL:    result = op_a >> op_b[SHAMT_W-1:0];
			OP_SRA:    result = $signed(op_a) >>> op_b[SHAMT_W-1:0];
			OP_OR:     result = op_a | op_b;
			OP_AND:    result = op_a & op_b;
			OP_SUBU:   result = (op_a >= op_b) ? '0 : '1;  // Borrow mask
			OP_LUI:    result = upper;
			OP_AUIPC:  result = req.pc + upper;
			OP_MUL:    result = product[XLEN-1:0];
			OP_MULH,
			OP_MULHSU,
			OP_MULHU:  result = product[2*XLEN-1:XLEN];
			OP_DIV,
			OP_DIVU:   result = quotient;
			OP_REM,
			OP_REMU:   result = remainder;
			default:   result = '0;
		endcase
	end

	// Decode needs a defined op
	always_comb begin
		assert final (!$isunknown(req.op))
			else $error("int_alu: unknown op %b", req.op);
	end

endmodule

// ==== latency_timer.sv ====
`timescale 1ns/1ns

module latency_timer
	import alu_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  lat_t load_value,
	output logic expired
);

	lat_t count;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			count <= '0;
		else if (load)
			count <= load_value;
		else if (count != '0)
			count <= count - 1'b1;  // Stops at zero
	end

	assign expired = (count == '0);

	// Controller only starts a new op once the previous latency ran out
	a_load_idle: assert property (@(posedge clk) disable iff (reset) load |-> expired);

endmodule

// ==== pipe_div.sv ====
`timescale 1ns/1ns

module pipe_div
	import alu_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  word_t numer,
	input  word_t denom,
	input  logic  is_signed,
	output word_t quotient,
	output word_t remainder
);

	typedef struct packed {
		word_t n;         // Dividend magnitude, shifted out MSB first
		word_t d;         // Divisor magnitude
		word_t r;         // Partial remainder
		word_t q;
		word_t dividend;  // Original value for divide by zero
	} div_data_t;

	typedef struct packed {
		logic neg_q;
		logic neg_r;
		logic div_zero;
		logic overflow;
	} div_flags_t;

	div_data_t  data  [DIV_STEPS+1];
	div_flags_t flags [DIV_STEPS+1];
	logic       neg_n;
	logic       neg_d;

	// One restoring step, one quotient bit
	function automatic div_data_t div_step(div_data_t s);
		div_data_t   o;
		logic [32:0] shifted;
		logic [32:0] diff;
		o = s;
		shifted = {s.r, s.n[XLEN-1]};
		diff = shifted - {1'b0, s.d};
		o.n = s.n << 1;
		o.r = diff[32] ? shifted[XLEN-1:0] : diff[XLEN-1:0];
		o.q = {s.q[XLEN-2:0], ~diff[32]};
		return o;
	endfunction

	assign neg_n = is_signed & numer[XLEN-1];
	assign neg_d = is_signed & denom[XLEN-1];

	always_ff @(posedge clk) begin
		data[0].n        <= neg_n ? -numer : numer;
		data[0].d        <= neg_d ? -denom : denom;
		data[0].r        <= '0;
		data[0].q        <= '0;
		data[0].dividend <= numer;
		for (int i = 1; i <= DIV_STEPS; i++)
			data[i] <= div_step(div_step(data[i-1]));
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i <= DIV_STEPS; i++)
				flags[i] <= '0;
		end else begin
			flags[0].neg_q    <= neg_n ^ neg_d;
			flags[0].neg_r    <= neg_n;  // Remainder takes the dividend sign
			flags[0].div_zero <= (denom == '0);
			flags[0].overflow <= is_signed && (numer == 32'h8000_0000) && (denom == '1);
			for (int i = 1; i <= DIV_STEPS; i++)
				flags[i] <= flags[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (flags[DIV_STEPS].div_zero) begin
			quotient  <= '1;
			remainder <= data[DIV_STEPS].dividend;
		end else if (flags[DIV_STEPS].overflow) begin
			quotient  <= 32'h8000_0000;
			remainder <= '0;
		end else begin
			quotient  <= flags[DIV_STEPS].neg_q ? -data[DIV_STEPS].q : data[DIV_STEPS].q;
			remainder <= flags[DIV_STEPS].neg_r ? -data[DIV_STEPS].r : data[DIV_STEPS].r;
		end
	end

	// X on divisor or sign input would land here
	a_flags_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(flags[DIV_STEPS]));

endmodule

// ==== pipe_mult.sv ====
`timescale 1ns/1ns

module pipe_mult
	import alu_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  dword_t a,
	input  dword_t b,
	output dword_t product
);

	// One byte of b is consumed per stage
	typedef struct packed {
		dword_t a;
		dword_t b;    // Bytes still to be multiplied, next one in [7:0]
		dword_t sum;  // Partial product so far
	} mul_stage_t;

	mul_stage_t stage [MUL_LATENCY];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < MUL_LATENCY; i++)
				stage[i] <= '0;
		end else begin
			stage[0].a   <= a;
			stage[0].b   <= b >> 8;
			stage[0].sum <= a * b[7:0];
			for (int i = 1; i < MUL_LATENCY; i++) begin
				stage[i].a   <= stage[i-1].a;
				stage[i].b   <= stage[i-1].b >> 8;
				stage[i].sum <= stage[i-1].sum +
					((stage[i-1].a * stage[i-1].b[7:0]) << (8 * i));
			end
		end
	end

	assign product = stage[MUL_LATENCY-1].sum;  // Low 64 bits only

endmodule

// ==== stall_fsm.sv ====
`timescale 1ns/1ns

module stall_fsm
	import alu_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  alu_op_t op,
	input  logic    expired,
	output logic    load,
	output lat_t    load_value,
	output logic    stall
);

	stall_state_e state_q;
	stall_state_e state_d;
	logic         is_mul;
	logic         is_div;

	assign is_mul = (op == OP_MUL) || (op == OP_MULH) || (op == OP_MULHSU) || (op == OP_MULHU);
	assign is_div = (op == OP_DIV) || (op == OP_DIVU) || (op == OP_REM) || (op == OP_REMU);

	always_comb begin
		state_d    = state_q;
		load       = 1'b0;
		load_value = '0;
		stall      = 1'b0;
		case (state_q)
			ST_IDLE: if (is_mul || is_div) begin
				stall      = 1'b1;  // Cycle 0 of a long op
				load       = 1'b1;
				load_value = is_div ? lat_t'(DIV_LATENCY - 1) : lat_t'(MUL_LATENCY - 1);
				state_d    = ST_BUSY;
			end
			ST_BUSY: begin
				stall = ~expired;
				if (expired)
					state_d = ST_IDLE;  // Op retires this cycle
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	// Upstream must hold the instruction while it is in flight
	a_op_held: assert property (@(posedge clk) disable iff (reset)
		(state_q == ST_BUSY) |-> $stable(op));

endmodule

// ==== tb_alu_unit.sv ====
`timescale 1ns/1ns

module tb_alu_unit
	import alu_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int RANDOM_TESTS = 40;
	localparam int MAX_VECTORS = 256;

	logic     clk;
	logic     reset;
	alu_req_t req;
	word_t    result;
	logic     stall;

	alu_req_t    vec_req [MAX_VECTORS];
	word_t       vec_expected [MAX_VECTORS];
	int          n_vectors;
	logic        vectors_loaded;
	int          errors;
	int          tests_run;
	logic [31:0] lcg_state;

	alu_unit dut (
		.clk    (clk),
		.reset  (reset),
		.req    (req),
		.result (result),
		.stall  (stall)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int stall_cycles_for(input alu_op_t op);
		case (op)
			OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: return MUL_LATENCY;
			OP_DIV, OP_DIVU, OP_REM, OP_REMU:     return DIV_LATENCY;
			default:                              return 0;
		endcase
	endfunction

	// Reference for the random ops only
	function automatic word_t reference_result(input alu_op_t op, input word_t a, input word_t b);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_XOR:  return a ^ b;
			OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
			default: return '0;
		endcase
	endfunction

	function automatic alu_op_t pick_random_op(input logic [1:0] sel);
		case (sel)
			2'd0:    return OP_ADD;
			2'd1:    return OP_SUB;
			2'd2:    return OP_XOR;
			default: return OP_SLTU;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic load_vectors();
		int          fd;
		int          fields;
		string       line;
		logic [31:0] col [8];
		fd = $fopen("alu_unit_stim.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open stimulus file alu_unit_stim.txt");
			errors++;
			return;
		end
		while (!$feof(fd) && n_vectors < MAX_VECTORS) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#")
				continue;  // Blank or column header
			fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
				col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7]);
			if (fields != 8) begin
				$display("ERROR: malformed stimulus line: %s", line);
				errors++;
			end else begin
				vec_req[n_vectors]           = '0;
				vec_req[n_vectors].op        = col[0][4:0];
				vec_req[n_vectors].rs1       = col[1];
				vec_req[n_vectors].rs2       = col[2];
				vec_req[n_vectors].use_imm   = col[3][0];
				vec_req[n_vectors].itype_imm = col[4];
				vec_req[n_vectors].upper_imm = col[5][UIMM_W-1:0];
				vec_req[n_vectors].pc        = col[6];
				vec_expected[n_vectors]      = col[7];
				n_vectors++;
			end
		end
		$fclose(fd);
	endtask

	// Apply one request, count stall cycles, check result once stall drops
	task automatic run_one(input alu_req_t r, input word_t expected, input string label);
		int stall_count;
		int errors_before;
		errors_before = errors;
		stall_count = 0;
		@(posedge clk);
		#DRIVE_DELAY;
		req = r;
		@(negedge clk);
		while (stall === 1'b1 && stall_count <= DIV_LATENCY + 2) begin
			stall_count++;
			@(negedge clk);
		end
		if (stall !== 1'b0) begin
			$display("ERROR: stall did not drop after %0d cycles for op %h", stall_count, r.op);
			errors++;
		end else begin
			check_value("result", expected, result);
		end
		check_value("stall_cycles", stall_cycles_for(r.op), stall_count);
		tests_run++;
		$display("test %0d %s op %h: %s, %0d stall cycles", tests_run, label, r.op,
			(errors == errors_before) ? "ok" : "FAILED", stall_count);
	endtask

	initial begin
		alu_req_t r;
		word_t    expected;
		errors = 0;
		tests_run = 0;
		n_vectors = 0;
		vectors_loaded = 1'b0;
		lcg_state = 32'h7e8f_3b26;
		req = '0;
		reset = 1'b1;

		load_vectors();
		vectors_loaded = 1'b1;

		repeat (5) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		@(negedge clk);
		check_value("stall", 1'b0, stall);  // Idle after reset

		for (int i = 0; i < n_vectors; i++)
			run_one(vec_req[i], vec_expected[i], "file");

		for (int i = 0; i < RANDOM_TESTS; i++) begin
			r = '0;
			lcg_state = lcg_next(lcg_state);
			r.op = pick_random_op(lcg_state[31:30]);
			r.use_imm = lcg_state[20];
			r.itype_imm = {{20{lcg_state[15]}}, lcg_state[15:4]};  // Sign-extended 12 bits
			lcg_state = lcg_next(lcg_state);
			r.rs1 = lcg_state;
			lcg_state = lcg_next(lcg_state);
			r.rs2 = lcg_state;
			expected = reference_result(r.op, r.rs1, r.use_imm ? r.itype_imm : r.rs2);
			run_one(r, expected, "random");
		end

		$display("Tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// Worst case per test is one divide plus a cycle of slack each side
	initial begin
		wait (vectors_loaded === 1'b1);
		#((n_vectors + RANDOM_TESTS) * (DIV_LATENCY + 2) * CLK_PERIOD + 20 * CLK_PERIOD);
		$display("ERROR: watchdog timeout, tests did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule
